// File: rtl/shadow_bank_settings.svh
/* Bank geometry. The register map holds at most four SHADOW words below LOCK_STATUS,
   so SB_NUM_CHANNELS must stay at 4 or less and be a power of two */
`ifndef SHADOW_BANK_SETTINGS_SVH
`define SHADOW_BANK_SETTINGS_SVH

// Width of the staging and shadow words
`define SB_DATA_WIDTH 16

// Channels in the bank
`define SB_NUM_CHANNELS 4

// AXI byte address width
`define SB_ADDR_WIDTH 6

`endif

// File: rtl/shadow_bank_pkg.sv
/* Types shared by the shadow bank. The channel index is sized from SB_NUM_CHANNELS
   and the bus data width is fixed at 32 bits */
`include "shadow_bank_settings.svh"

package shadow_bank_pkg;

    typedef logic [`SB_DATA_WIDTH-1:0] sb_data_t;
    typedef logic [$clog2(`SB_NUM_CHANNELS)-1:0] sb_chan_t;

    typedef logic [`SB_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0] axil_resp_t;

    // AXI response codes
    localparam axil_resp_t OKAY = 2'b00;
    localparam axil_resp_t SLVERR = 2'b10;

    // One register write from the bus
    typedef struct packed {
        axil_addr_t addr;
        axil_data_t data;
    } reg_wr_req_t;

    typedef struct packed {
        axil_addr_t addr;
    } reg_rd_req_t;

    // Command into the lock pipeline
    typedef struct packed {
        sb_chan_t chan;
        sb_data_t data;
        logic capture;
        logic lock;
        logic unlock;
    } shadow_cmd_t;

    // Result of one applied command
    typedef struct packed {
        sb_chan_t chan;
        sb_data_t data;
        logic locked;
    } shadow_update_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_REQUEST,
        WR_RESPONSE
    } axil_wr_state_t;

endpackage

// File: rtl/axil_reg_port.sv
/* AXI4-Lite slave with one write and one read in flight, no strobes or protection.
   AW and W are taken together, a lone AW or W waits without a handshake */
`timescale 1ns/100ps

module axil_reg_port (
    input  logic                         clk,
    input  logic                         rst_n,
    // Write address and data
    input  logic                         awvalid,
    output logic                         awready,
    input  shadow_bank_pkg::axil_addr_t  awaddr,
    input  logic                         wvalid,
    output logic                         wready,
    input  shadow_bank_pkg::axil_data_t  wdata,
    // Write response
    output logic                         bvalid,
    input  logic                         bready,
    output shadow_bank_pkg::axil_resp_t  bresp,
    // Read address and data
    input  logic                         arvalid,
    output logic                         arready,
    input  shadow_bank_pkg::axil_addr_t  araddr,
    output logic                         rvalid,
    input  logic                         rready,
    output shadow_bank_pkg::axil_data_t  rdata,
    output shadow_bank_pkg::axil_resp_t  rresp,
    // Register side
    output logic                         wr_req_valid,
    output shadow_bank_pkg::reg_wr_req_t wr_req,
    input  logic                         wr_ack,
    input  logic                         wr_err,
    output logic                         rd_req_valid,
    output shadow_bank_pkg::reg_rd_req_t rd_req,
    input  logic                         rd_ack,
    input  shadow_bank_pkg::axil_data_t  rd_data,
    input  logic                         rd_err
);
    import shadow_bank_pkg::*;

    axil_wr_state_t wr_state;
    axil_wr_state_t wr_state_next;
    logic port_en;
    logic wr_accept;
    logic rd_accept;
    logic rd_wait;
    logic rd_busy;

    // Bus side opens one cycle after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            port_en <= 1'b0;
        end else begin
            port_en <= 1'b1;
        end
    end

    // Write handshake needs both AW and W present
    assign awready   = port_en && (wr_state == WR_IDLE) && awvalid && wvalid;
    assign wready    = awready;
    assign wr_accept = awready;

    assign wr_req_valid = (wr_state == WR_REQUEST);
    assign bvalid       = (wr_state == WR_RESPONSE);

    always_comb begin
        wr_state_next = wr_state;
        case (wr_state)
            WR_IDLE: begin
                if (wr_accept) begin
                    wr_state_next = WR_REQUEST;
                end
            end
            WR_REQUEST: begin
                // Held here while a CMD write waits for the pipeline
                if (wr_ack) begin
                    wr_state_next = WR_RESPONSE;
                end
            end
            WR_RESPONSE: begin
                if (bready) begin
                    wr_state_next = WR_IDLE;
                end
            end
            default: begin
                wr_state_next = WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            wr_state <= wr_state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            wr_req.addr <= awaddr;
            wr_req.data <= wdata;
        end
        if (wr_req_valid && wr_ack) begin
            bresp <= wr_err ? SLVERR : OKAY;
        end
    end

    // Read path: request one cycle after AR, data the cycle after that
    assign rd_busy   = rd_req_valid || rd_wait || rvalid;
    assign arready   = port_en && !rd_busy;
    assign rd_accept = arvalid && arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_req_valid <= 1'b0;
            rd_wait      <= 1'b0;
            rvalid       <= 1'b0;
        end else begin
            rd_req_valid <= rd_accept;
            rd_wait      <= rd_req_valid;
            if (rd_ack) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rd_req.addr <= araddr;
        end
        if (rd_ack) begin
            rdata <= rd_data;
            rresp <= rd_err ? SLVERR : OKAY;
        end
    end

endmodule

// File: rtl/shadow_regs.sv
/* Register map of the bank. SHADOW words start at 0x10 and must end at or below 0x20;
   a CMD write is held until the pipeline takes it */
`timescale 1ns/100ps
`include "shadow_bank_settings.svh"

module shadow_regs (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 wr_req_valid,
    input  shadow_bank_pkg::reg_wr_req_t                         wr_req,
    output logic                                                 wr_ack,
    output logic                                                 wr_err,
    input  logic                                                 rd_req_valid,
    input  shadow_bank_pkg::reg_rd_req_t                         rd_req,
    output logic                                                 rd_ack,
    output shadow_bank_pkg::axil_data_t                          rd_data,
    output logic                                                 rd_err,
    output logic                                                 cmd_valid,
    output shadow_bank_pkg::shadow_cmd_t                         cmd,
    input  logic                                                 cmd_ready,
    input  shadow_bank_pkg::sb_data_t [`SB_NUM_CHANNELS-1:0]     shadow_values,
    input  logic [`SB_NUM_CHANNELS-1:0]                          locked
);
    import shadow_bank_pkg::*;

    localparam int CHAN_W = $bits(sb_chan_t);

    localparam axil_addr_t ADDR_STAGE_DATA  = axil_addr_t'('h00);
    localparam axil_addr_t ADDR_CMD         = axil_addr_t'('h04);
    localparam axil_addr_t ADDR_SHADOW_BASE = axil_addr_t'('h10);
    localparam axil_addr_t ADDR_SHADOW_END  = axil_addr_t'('h10 + 4 * `SB_NUM_CHANNELS);
    localparam axil_addr_t ADDR_LOCK_STATUS = axil_addr_t'('h20);

    sb_data_t stage_data;
    logic wr_is_stage;
    logic wr_is_cmd;
    axil_data_t rd_data_d;
    logic rd_err_d;

    function automatic logic is_shadow(axil_addr_t addr);
        return (addr >= ADDR_SHADOW_BASE) && (addr < ADDR_SHADOW_END) &&
               (addr[1:0] == 2'b00);
    endfunction

    function automatic sb_chan_t shadow_chan(axil_addr_t addr);
        axil_addr_t offset;
        offset = addr - ADDR_SHADOW_BASE;
        return offset[CHAN_W+1:2];
    endfunction

    // Write decode
    assign wr_is_stage = (wr_req.addr == ADDR_STAGE_DATA);
    assign wr_is_cmd   = (wr_req.addr == ADDR_CMD);

    assign cmd_valid = wr_req_valid && wr_is_cmd;
    // CMD is acknowledged together with the pipeline handshake
    assign wr_ack    = wr_req_valid && (!wr_is_cmd || cmd_ready);
    assign wr_err    = wr_req_valid && !wr_is_stage && !wr_is_cmd;

    // Command word: channel in 1:0, capture 4, lock 5, unlock 6
    assign cmd.chan    = wr_req.data[CHAN_W-1:0];
    assign cmd.data    = stage_data;
    assign cmd.capture = wr_req.data[4];
    assign cmd.lock    = wr_req.data[5];
    assign cmd.unlock  = wr_req.data[6];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_data <= '0;
        end else if (wr_req_valid && wr_is_stage) begin
            stage_data <= wr_req.data[`SB_DATA_WIDTH-1:0];
        end
    end

    // Readback mux
    always_comb begin
        rd_data_d = '0;
        rd_err_d  = 1'b0;
        if (rd_req.addr == ADDR_STAGE_DATA) begin
            rd_data_d[`SB_DATA_WIDTH-1:0] = stage_data;
        end else if (rd_req.addr == ADDR_CMD) begin
            // Write only, reads back as zero
            rd_data_d = '0;
        end else if (is_shadow(rd_req.addr)) begin
            rd_data_d[`SB_DATA_WIDTH-1:0] = shadow_values[shadow_chan(rd_req.addr)];
        end else if (rd_req.addr == ADDR_LOCK_STATUS) begin
            rd_data_d[`SB_NUM_CHANNELS-1:0] = locked;
        end else begin
            rd_err_d = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req_valid) begin
            rd_data <= rd_data_d;
            rd_err  <= rd_err_d;
        end
    end

endmodule

// File: rtl/shadow_lock_pipe.sv
/* Three-stage command pipeline; shadow and lock state live only in stage 3.
   Holds up to three commands, a low update_ready stalls back to cmd_ready */
`timescale 1ns/100ps
`include "shadow_bank_settings.svh"

module shadow_lock_pipe (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             cmd_valid,
    input  shadow_bank_pkg::shadow_cmd_t                     cmd,
    output logic                                             cmd_ready,
    output logic                                             update_valid,
    output shadow_bank_pkg::shadow_update_t                  update,
    input  logic                                             update_ready,
    output shadow_bank_pkg::sb_data_t [`SB_NUM_CHANNELS-1:0] shadow_values,
    output logic [`SB_NUM_CHANNELS-1:0]                      locked
);
    import shadow_bank_pkg::*;

    localparam int NUM_CH = `SB_NUM_CHANNELS;

    logic s1_valid;
    shadow_cmd_t s1_cmd;
    logic [NUM_CH-1:0] s1_onehot;

    logic s2_valid;
    sb_chan_t s2_chan;
    logic [NUM_CH-1:0] s2_en;
    sb_data_t s2_data;
    logic s2_capture;
    logic s2_lock_set;
    logic s2_lock_clr;

    logic s1_load;
    logic s2_load;
    logic s3_load;
    logic s2_free;
    logic s3_free;

    sb_data_t cur_shadow;
    sb_data_t new_data;
    logic cur_locked;
    logic new_locked;

    // A stage takes new data when empty or when its content moves on
    assign s3_free   = !update_valid || update_ready;
    assign s2_free   = !s2_valid || s3_free;
    assign cmd_ready = !s1_valid || s2_free;

    assign s1_load = cmd_valid && cmd_ready;
    assign s2_load = s1_valid && s2_free;
    assign s3_load = s2_valid && s3_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            update_valid <= 1'b0;
        end else begin
            if (cmd_ready) begin
                s1_valid <= cmd_valid;
            end
            if (s2_free) begin
                s2_valid <= s1_valid;
            end
            if (s3_free) begin
                update_valid <= s2_valid;
            end
        end
    end

    // Channel select for stage 2
    always_comb begin
        s1_onehot = '0;
        s1_onehot[s1_cmd.chan] = 1'b1;
    end

    // Current state of the addressed channel, then the command applied to it
    always_comb begin
        cur_shadow = shadow_values[s2_chan];
        cur_locked = |(s2_en & locked);
        new_data   = (s2_capture && !cur_locked) ? s2_data : cur_shadow;
        if (s2_lock_set) begin
            new_locked = 1'b1;
        end else if (s2_lock_clr) begin
            new_locked = 1'b0;
        end else begin
            new_locked = cur_locked;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_cmd <= cmd;
        end
        if (s2_load) begin
            s2_chan     <= s1_cmd.chan;
            s2_en       <= s1_onehot;
            s2_data     <= s1_cmd.data;
            s2_capture  <= s1_cmd.capture;
            // Lock with unlock resolves to hold
            s2_lock_set <= s1_cmd.lock && !s1_cmd.unlock;
            s2_lock_clr <= s1_cmd.unlock && !s1_cmd.lock;
        end
        if (s3_load) begin
            update.chan   <= s2_chan;
            update.data   <= new_data;
            update.locked <= new_locked;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow_values <= '0;
            locked        <= '0;
        end else if (s3_load) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (s2_en[ch]) begin
                    shadow_values[ch] <= new_data;
                    locked[ch]        <= new_locked;
                end
            end
        end
    end

endmodule

// File: rtl/shadow_bank_top.sv
/* Shadow bank behind AXI4-Lite; update_ready back-pressure can hold off bvalid
   of a CMD write for as long as the stream stalls */
`timescale 1ns/100ps
`include "shadow_bank_settings.svh"

module shadow_bank_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            awvalid,
    output logic                            awready,
    input  shadow_bank_pkg::axil_addr_t     awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  shadow_bank_pkg::axil_data_t     wdata,
    output logic                            bvalid,
    input  logic                            bready,
    output shadow_bank_pkg::axil_resp_t     bresp,
    input  logic                            arvalid,
    output logic                            arready,
    input  shadow_bank_pkg::axil_addr_t     araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output shadow_bank_pkg::axil_data_t     rdata,
    output shadow_bank_pkg::axil_resp_t     rresp,
    output logic                            update_valid,
    output shadow_bank_pkg::shadow_update_t update,
    input  logic                            update_ready,
    output logic [`SB_NUM_CHANNELS-1:0]     locked
);
    import shadow_bank_pkg::*;

    logic wr_req_valid;
    reg_wr_req_t wr_req;
    logic wr_ack;
    logic wr_err;
    logic rd_req_valid;
    reg_rd_req_t rd_req;
    logic rd_ack;
    axil_data_t rd_data;
    logic rd_err;

    logic cmd_valid;
    shadow_cmd_t cmd;
    logic cmd_ready;
    sb_data_t [`SB_NUM_CHANNELS-1:0] shadow_values;

    axil_reg_port i_axil_reg_port (
        .clk, .rst_n,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
        .wr_req_valid, .wr_req, .wr_ack, .wr_err,
        .rd_req_valid, .rd_req, .rd_ack, .rd_data, .rd_err
    );

    shadow_regs i_shadow_regs (
        .clk, .rst_n,
        .wr_req_valid, .wr_req, .wr_ack, .wr_err,
        .rd_req_valid, .rd_req, .rd_ack, .rd_data, .rd_err,
        .cmd_valid, .cmd, .cmd_ready,
        .shadow_values, .locked
    );

    shadow_lock_pipe i_shadow_lock_pipe (
        .clk, .rst_n,
        .cmd_valid, .cmd, .cmd_ready,
        .update_valid, .update, .update_ready,
        .shadow_values, .locked
    );

endmodule

// File: verification/shadow_bank_properties.sv
/* Handshake checks for one valid/ready channel, bound once per channel.
   payload is only checked while a transfer is waiting */
`timescale 1ns/100ps

module shadow_bank_properties #(
    parameter int W = 1
) (
    input logic         clk,
    input logic         rst_n,
    input logic         valid,
    input logic         ready,
    input logic [W-1:0] payload
);

    // Once raised, valid stays up until the transfer
    assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid)
        else $error("valid dropped before the handshake");

    // Payload held while the receiver stalls
    assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> $stable(payload))
        else $error("payload changed while waiting for ready");

    // Nothing is offered right after reset release
    assert property (@(posedge clk)
        $rose(rst_n) |-> !valid)
        else $error("valid high directly after reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(valid))
        else $error("valid is unknown");

endmodule

// File: verification/shadow_bank_tb.sv
/* Testbench for the shadow bank. Cases come from verification/shadow_bank_cases.txt,
   read relative to the project root; reads wait until all updates are drained */
`timescale 1ns/100ps
`include "shadow_bank_settings.svh"

module shadow_bank_tb;
    import shadow_bank_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 16;
    localparam int CASE_CYCLES = 64;
    localparam int NUM_CH = `SB_NUM_CHANNELS;
    localparam logic [15:0] LFSR_SEED = 16'd24059;

    // One line of the case file
    typedef struct packed {
        logic is_read;
        axil_addr_t addr;
        axil_data_t data;
        axil_resp_t resp;
        axil_data_t rdata;
    } bus_case_t;

    // Expected update plus the lock vector seen with it
    typedef struct packed {
        shadow_update_t upd;
        logic [NUM_CH-1:0] locked_vec;
    } exp_update_t;

    logic clk;
    logic rst_n;
    logic awvalid;
    logic awready;
    axil_addr_t awaddr;
    logic wvalid;
    logic wready;
    axil_data_t wdata;
    logic bvalid;
    logic bready;
    axil_resp_t bresp;
    logic arvalid;
    logic arready;
    axil_addr_t araddr;
    logic rvalid;
    logic rready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic update_valid;
    shadow_update_t update;
    logic update_ready;
    logic [NUM_CH-1:0] locked;

    bus_case_t cases[$];
    exp_update_t exp_q[$];
    bit cases_loaded;
    int error_count;
    int check_count;
    logic [15:0] lfsr;

    // Reference state of the bank
    sb_data_t model_stage;
    sb_data_t model_shadow [NUM_CH];
    logic [NUM_CH-1:0] model_locked;

    shadow_bank_top i_shadow_bank_top (.*);

    bind shadow_lock_pipe shadow_bank_properties #(
        .W($bits(shadow_bank_pkg::shadow_update_t))
    ) i_update_props (
        .clk(clk), .rst_n(rst_n), .valid(update_valid), .ready(update_ready), .payload(update)
    );
    bind axil_reg_port shadow_bank_properties #(.W(2)) i_bresp_props (
        .clk(clk), .rst_n(rst_n), .valid(bvalid), .ready(bready), .payload(bresp)
    );
    bind axil_reg_port shadow_bank_properties #(.W(34)) i_rdata_props (
        .clk(clk), .rst_n(rst_n), .valid(rvalid), .ready(rready), .payload({rdata, rresp})
    );

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_random_bit(output logic bit_out);
        bit_out = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic load_cases();
        int fd;
        int n;
        logic [7:0] op_char;
        logic [8*128-1:0] skip_line;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_resp;
        logic [31:0] f_rdata;
        bus_case_t bc;
        fd = $fopen("verification/shadow_bank_cases.txt", "r");
        if (fd == 0) begin
            report_error("could not open the case file");
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", op_char);
            if (n != 1) begin
                break;
            end
            if (op_char == "#") begin
                void'($fgets(skip_line, fd));
                continue;
            end
            n = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_resp, f_rdata);
            if (n != 4) begin
                report_error("malformed line in the case file");
                break;
            end
            if (op_char != "R" && op_char != "W") begin
                report_error("unknown operation in the case file");
                continue;
            end
            bc.is_read = (op_char == "R");
            bc.addr = axil_addr_t'(f_addr);
            bc.data = f_data;
            bc.resp = axil_resp_t'(f_resp);
            bc.rdata = f_rdata;
            cases.push_back(bc);
        end
        $fclose(fd);
    endtask

    // Lock and capture rules, applied in issue order
    task automatic model_write(input axil_addr_t addr, input axil_data_t data);
        exp_update_t next_upd;
        sb_chan_t ch;
        if (addr == 6'h00) begin
            model_stage = data[`SB_DATA_WIDTH-1:0];
        end else if (addr == 6'h04) begin
            ch = data[$bits(sb_chan_t)-1:0];
            if (data[4] && !model_locked[ch]) begin
                model_shadow[ch] = model_stage;
            end
            if (data[5] && !data[6]) begin
                model_locked[ch] = 1'b1;
            end else if (data[6] && !data[5]) begin
                model_locked[ch] = 1'b0;
            end
            next_upd.upd.chan = ch;
            next_upd.upd.data = model_shadow[ch];
            next_upd.upd.locked = model_locked[ch];
            next_upd.locked_vec = model_locked;
            exp_q.push_back(next_upd);
        end
    endtask

    task automatic drain_updates();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic bus_write(input bus_case_t bc);
        model_write(bc.addr, bc.data);
        awaddr = bc.addr;
        wdata = bc.data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        forever begin
            @(negedge clk);
            if (awready) begin
                break;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        compare_value("wready", wready, 1);
        @(posedge clk);
        #DRIVE_DELAY;
        awvalid = 1'b0;
        wvalid = 1'b0;
        forever begin
            @(negedge clk);
            if (bvalid && bready) begin
                break;
            end
        end
        compare_value("bresp", bresp, bc.resp);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic bus_read(input bus_case_t bc);
        int wait_cycles;
        drain_updates();
        araddr = bc.addr;
        arvalid = 1'b1;
        forever begin
            @(negedge clk);
            if (arready) begin
                break;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        arvalid = 1'b0;
        wait_cycles = 0;
        forever begin
            @(negedge clk);
            if (rvalid) begin
                break;
            end
            wait_cycles++;
        end
        // rvalid is due two cycles after the AR handshake
        compare_value("rvalid latency", wait_cycles, 2);
        while (!rready) begin
            @(negedge clk);
        end
        compare_value("rresp", rresp, bc.resp);
        compare_value("rdata", rdata, bc.rdata);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_update();
        exp_update_t expected;
        if (exp_q.size() == 0) begin
            report_error("update handshake with no command outstanding");
        end else begin
            expected = exp_q.pop_front();
            compare_value("update.chan", update.chan, expected.upd.chan);
            compare_value("update.data", update.data, expected.upd.data);
            compare_value("update.locked", update.locked, expected.upd.locked);
            compare_value("locked", locked, expected.locked_vec);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Random ready for the update stream and the B and R channels
    initial begin
        lfsr = LFSR_SEED;
        update_ready = 1'b0;
        bready = 1'b0;
        rready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            take_random_bit(update_ready);
            take_random_bit(bready);
            take_random_bit(rready);
        end
    end

    // Update stream monitor, handshake happens at the following edge
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && update_valid && update_ready) begin
                check_update();
            end
        end
    end

    initial begin
        int limit;
        wait (cases_loaded);
        limit = RESET_CYCLES + (cases.size() + 1) * CASE_CYCLES;
        repeat (limit) @(posedge clk);
        report_error($sformatf("timeout, run exceeded %0d cycles", limit));
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Errors found");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        arvalid = 1'b0;
        araddr = '0;
        error_count = 0;
        check_count = 0;
        model_stage = '0;
        model_locked = '0;
        foreach (model_shadow[i]) begin
            model_shadow[i] = '0;
        end
        load_cases();
        cases_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        compare_value("update_valid", update_valid, 0);
        foreach (cases[i]) begin
            if (cases[i].is_read) begin
                bus_read(cases[i]);
            end else begin
                bus_write(cases[i]);
            end
        end
        drain_updates();
        // A few idle cycles to catch stray updates
        repeat (4) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verification/shadow_bank_cases.txt
# Columns: op (W write, R read), addr, wdata, expected resp, expected rdata, all hex
# rdata is ignored on W lines; resp 0 is OKAY and 2 is SLVERR
R 10 00000000 0 00000000
R 14 00000000 0 00000000
R 18 00000000 0 00000000
R 1c 00000000 0 00000000
R 20 00000000 0 00000000
W 00 0000a5a5 0 00000000
W 04 00000011 0 00000000
R 14 00000000 0 0000a5a5
R 10 00000000 0 00000000
R 18 00000000 0 00000000
W 00 00001234 0 00000000
W 04 00000032 0 00000000
R 20 00000000 0 00000004
W 00 0000beef 0 00000000
W 04 00000012 0 00000000
R 18 00000000 0 00001234
W 04 00000052 0 00000000
R 18 00000000 0 00001234
R 20 00000000 0 00000000
W 04 00000023 0 00000000
W 04 00000063 0 00000000
W 04 00000061 0 00000000
R 20 00000000 0 00000008
W 14 0000ffff 2 00000000
W 20 0000000f 2 00000000
W 3c 00000001 2 00000000
R 14 00000000 0 0000a5a5
R 20 00000000 0 00000008
R 04 00000000 0 00000000
R 08 00000000 2 00000000
R 12 00000000 2 00000000
R 3c 00000000 2 00000000
W 00 00001111 0 00000000
W 04 00000010 0 00000000
W 00 00002222 0 00000000
W 04 00000030 0 00000000
W 00 dead3333 0 00000000
W 04 00000010 0 00000000
W 04 00000013 0 00000000
W 04 00000053 0 00000000
W 04 00000013 0 00000000
W 04 00000040 0 00000000
R 10 00000000 0 00002222
R 1c 00000000 0 00003333
R 14 00000000 0 0000a5a5
R 18 00000000 0 00001234
R 20 00000000 0 00000000
R 00 00000000 0 00003333

// File: shadow_bank_top.f
+incdir+rtl
rtl/shadow_bank_pkg.sv
rtl/axil_reg_port.sv
rtl/shadow_regs.sv
rtl/shadow_lock_pipe.sv
rtl/shadow_bank_top.sv
verification/shadow_bank_properties.sv
verification/shadow_bank_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the shadow bank testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f shadow_bank_top.f \
    --top-module shadow_bank_tb \
    --Mdir obj_dir -o shadow_bank_sim

status=0
./obj_dir/shadow_bank_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

if [ "$status" -ne 0 ] || ! grep -qx "No errors" sim.log; then
    echo "Simulation did not complete"
    exit 1
fi

echo "Simulation PASSED"
